/* hw/c4_pkg.sv */
package c4_pkg;

	//////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////

	typedef logic [1:0]  piece_t;     // Cell code
	typedef logic [2:0]  col_t;
	typedef logic [2:0]  row_t;       // Row 0 is the top row
	typedef logic [5:0]  cell_idx_t;  // Row * 7 + column
	typedef logic [2:0]  height_t;    // Pieces in one column
	typedef logic [97:0] board_t;     // Cell n at bits 2n+1:2n
	typedef logic [7:0]  pix_x_t;
	typedef logic [6:0]  pix_y_t;
	typedef logic [2:0]  color_t;     // RGB, one bit each
	typedef logic [9:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	typedef enum logic [0:0] {
		IDLE,
		DRAW
	} plot_state_t;

	//////////////////////////////////////////////////
	// Game geometry
	//////////////////////////////////////////////////

	localparam int NUM_COLS  = 7;
	localparam int NUM_ROWS  = 7;
	localparam int NUM_CELLS = NUM_COLS * NUM_ROWS;
	localparam int WIN_LEN   = 4;

	// Screen placement on the 160x120 grid
	localparam int CELL_PIX = 6;
	localparam int ORIGIN_X = 8;
	localparam int PITCH_X  = 22;
	localparam int ORIGIN_Y = 5;
	localparam int PITCH_Y  = 16;

	localparam color_t COLOR_P1 = 3'b100;  // Red
	localparam color_t COLOR_P2 = 3'b001;  // Blue

	localparam piece_t PIECE_EMPTY = 2'd0;
	localparam piece_t PIECE_P1    = 2'd1;
	localparam piece_t PIECE_P2    = 2'd2;

	// APB register map, byte addresses
	localparam apb_addr_t REG_MOVE      = 10'h000;
	localparam apb_addr_t REG_STATUS    = 10'h004;
	localparam apb_addr_t REG_CELL_BASE = 10'h080;

endpackage

/* hw/c4_apb_regs.sv */
`timescale 1ns/1ps

module c4_apb_regs (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  c4_pkg::apb_addr_t paddr,
	input  c4_pkg::apb_data_t pwdata,
	output c4_pkg::apb_data_t prdata,
	output logic              pready,
	output logic              pslverr,
	output logic              move_req,
	output c4_pkg::col_t      move_col,
	input  logic              move_ok,
	input  c4_pkg::board_t    board,
	input  c4_pkg::piece_t    turn,
	input  c4_pkg::piece_t    winner,
	input  logic              busy
);
	import c4_pkg::*;

	logic      access;
	apb_addr_t cell_off;
	cell_idx_t cell_idx;
	logic      cell_hit;
	apb_data_t status_word;
	piece_t    cell_val;

	//////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////

	assign access = psel && penable;  // Access phase only

	// Only the move register has any effect on a write
	assign move_req = access && pwrite && (paddr == REG_MOVE);
	assign move_col = pwdata[2:0];

	// No wait states
	assign pready = 1'b1;

	// Legality comes from the board
	assign pslverr = move_req && !move_ok;

	//////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////

	assign status_word = apb_data_t'({winner, turn, busy});  // Bits 4:3, 2:1, 0

	// Cell window starts at 0x80 with one word per cell
	assign cell_off = paddr - REG_CELL_BASE;
	assign cell_idx = cell_off[7:2];

	always_comb begin
		cell_hit = (paddr >= REG_CELL_BASE);
		if (cell_off[9:8] != 2'b00) begin
			cell_hit = 1'b0;  // Past the window
		end
		if (cell_off[1:0] != 2'b00) begin
			cell_hit = 1'b0;
		end
		if (int'(cell_idx) >= NUM_CELLS) begin
			cell_hit = 1'b0;
		end
	end

	assign cell_val = board[{cell_idx, 1'b0} +: 2];

	always_comb begin
		prdata = '0;  // Unmapped reads return zero
		if (paddr == REG_STATUS) begin
			prdata = status_word;
		end else if (cell_hit) begin
			prdata = apb_data_t'(cell_val);
		end
	end

	// A move into a busy plotter or a finished game is refused
	a_err_when_blocked: assert property (
		@(posedge clk) disable iff (!reset_n)
		(move_req && (busy || winner != PIECE_EMPTY)) |-> pslverr
	);

endmodule

/* hw/c4_board.sv */
`timescale 1ns/1ps

module c4_board (
	input  logic           clk,
	input  logic           reset_n,
	input  logic           move_req,
	input  c4_pkg::col_t   move_col,
	output logic           move_ok,
	input  logic           busy,
	input  logic           game_over,
	output c4_pkg::board_t board,
	output c4_pkg::piece_t turn,
	output logic           placed,
	output c4_pkg::col_t   placed_col,
	output c4_pkg::row_t   placed_row,
	output c4_pkg::piece_t placed_piece
);
	import c4_pkg::*;

	height_t   heights [NUM_COLS];  // Pieces stacked per column
	logic      col_ok;
	col_t      sel_col;
	height_t   sel_height;
	logic      col_full;
	row_t      land_row;
	cell_idx_t land_idx;
	logic      accept;

	//////////////////////////////////////////////////
	// Legality
	//////////////////////////////////////////////////

	assign col_ok  = (int'(move_col) < NUM_COLS);
	assign sel_col = col_ok ? move_col : '0;  // Keep the array index in range

	assign sel_height = heights[sel_col];
	assign col_full   = (int'(sel_height) == NUM_ROWS);

	// Piece drops to the lowest empty row
	assign land_row = row_t'(NUM_ROWS - 1) - sel_height;
	assign land_idx = cell_idx_t'(int'(land_row) * NUM_COLS + int'(sel_col));

	// placed also blocks a move, winner and busy are one cycle late then
	assign move_ok = col_ok && !col_full && !busy && !game_over && !placed;
	assign accept  = move_req && move_ok;

	//////////////////////////////////////////////////
	// Board state
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			board  <= '0;
			turn   <= PIECE_P1;  // Player 1 opens
			placed <= 1'b0;
			for (int c = 0; c < NUM_COLS; c++) begin
				heights[c] <= '0;
			end
		end else begin
			placed <= accept;
			if (accept) begin
				board[{land_idx, 1'b0} +: 2] <= turn;
				heights[sel_col] <= sel_height + 3'd1;
				turn <= (turn == PIECE_P1) ? PIECE_P2 : PIECE_P1;
			end
		end
	end

	// Where the new piece went, for the plotter
	always_ff @(posedge clk) begin
		if (accept) begin
			placed_col   <= sel_col;
			placed_row   <= land_row;
			placed_piece <= turn;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// A full column stays full, no wrap past seven
	for (genvar gc = 0; gc < NUM_COLS; gc++) begin : g_height_chk
		a_height_max: assert property (
			@(posedge clk) disable iff (!reset_n)
			(int'(heights[gc]) == NUM_ROWS) |=> (int'(heights[gc]) == NUM_ROWS)
		);
	end

	// Plotter must have finished before a new piece lands
	a_no_place_busy: assert property (
		@(posedge clk) disable iff (!reset_n)
		placed |-> !busy
	);

endmodule

/* hw/c4_win_check.sv */
`timescale 1ns/1ps

module c4_win_check (
	input  logic           clk,
	input  logic           reset_n,
	input  c4_pkg::board_t board,
	output c4_pkg::piece_t winner,
	output logic           game_over
);
	import c4_pkg::*;

	piece_t scan;  // Owner of the first complete window or empty

	//////////////////////////////////////////////////
	// Window helpers
	//////////////////////////////////////////////////

	function automatic piece_t cell_at(input board_t b, input int r, input int c);
		return b[2 * (r * NUM_COLS + c) +: 2];
	endfunction

	// Owner of a run of WIN_LEN cells starting at (r, c) in direction (dr, dc)
	function automatic piece_t window(
		input board_t b,
		input int     r,
		input int     c,
		input int     dr,
		input int     dc
	);
		piece_t first;
		logic   same;
		first = cell_at(b, r, c);
		same  = (first != PIECE_EMPTY);
		for (int i = 1; i < WIN_LEN; i++) begin
			if (cell_at(b, r + i * dr, c + i * dc) != first) begin
				same = 1'b0;
			end
		end
		return same ? first : PIECE_EMPTY;
	endfunction

	//////////////////////////////////////////////////
	// Full board scan
	//////////////////////////////////////////////////

	always_comb begin
		scan = PIECE_EMPTY;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int c = 0; c < NUM_COLS; c++) begin
				if (scan == PIECE_EMPTY && c <= NUM_COLS - WIN_LEN) begin
					scan = window(board, r, c, 0, 1);  // Horizontal
				end
				if (scan == PIECE_EMPTY && r <= NUM_ROWS - WIN_LEN) begin
					scan = window(board, r, c, 1, 0);  // Vertical
				end
				if (scan == PIECE_EMPTY && r <= NUM_ROWS - WIN_LEN &&
						c <= NUM_COLS - WIN_LEN) begin
					scan = window(board, r, c, 1, 1);  // Down and right
				end
				if (scan == PIECE_EMPTY && r <= NUM_ROWS - WIN_LEN &&
						c >= WIN_LEN - 1) begin
					scan = window(board, r, c, 1, -1);  // Down and left
				end
			end
		end
	end

	// First winner sticks until reset
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			winner <= PIECE_EMPTY;
		end else if (winner == PIECE_EMPTY) begin
			winner <= scan;
		end
	end

	assign game_over = (winner != PIECE_EMPTY);

	// Winning line stays on the board while the game is over
	a_win_kept: assert property (
		@(posedge clk) disable iff (!reset_n)
		game_over |-> (scan != PIECE_EMPTY)
	);

endmodule

/* hw/c4_cell_plotter.sv */
`timescale 1ns/1ps

module c4_cell_plotter (
	input  logic           clk,
	input  logic           reset_n,
	input  logic           placed,
	input  c4_pkg::col_t   placed_col,
	input  c4_pkg::row_t   placed_row,
	input  c4_pkg::piece_t placed_piece,
	output logic           busy,
	output logic           plot_valid,
	output c4_pkg::pix_x_t plot_x,
	output c4_pkg::pix_y_t plot_y,
	output c4_pkg::color_t plot_color
);
	import c4_pkg::*;

	plot_state_t state;
	pix_x_t      org_x;  // Top-left pixel of the square
	pix_y_t      org_y;
	color_t      color_q;
	logic [2:0]  off_x;
	logic [2:0]  off_y;
	logic        start;

	assign start = (state == IDLE) && placed;

	//////////////////////////////////////////////////
	// Sweep control
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
			off_x <= '0;
			off_y <= '0;
		end else begin
			case (state)
				IDLE: begin
					off_x <= '0;
					off_y <= '0;
					if (placed) state <= DRAW;
				end
				DRAW: begin
					if (int'(off_x) == CELL_PIX - 1) begin
						off_x <= '0;  // Next line of the square
						if (int'(off_y) == CELL_PIX - 1) begin
							off_y <= '0;
							state <= IDLE;  // Last pixel out
						end else begin
							off_y <= off_y + 3'd1;
						end
					end else begin
						off_x <= off_x + 3'd1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Origin and colour of the new piece
	always_ff @(posedge clk) begin
		if (start) begin
			org_x   <= pix_x_t'(ORIGIN_X + int'(placed_col) * PITCH_X);
			org_y   <= pix_y_t'(ORIGIN_Y + int'(placed_row) * PITCH_Y);
			color_q <= (placed_piece == PIECE_P1) ? COLOR_P1 : COLOR_P2;
		end
	end

	assign busy       = (state == DRAW);
	assign plot_valid = (state == DRAW);
	assign plot_x     = org_x + pix_x_t'(off_x);
	assign plot_y     = org_y + pix_y_t'(off_y);
	assign plot_color = color_q;

endmodule

/* hw/connect4_top.sv */
`timescale 1ns/1ps

module connect4_top (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  c4_pkg::apb_addr_t paddr,
	input  c4_pkg::apb_data_t pwdata,
	output c4_pkg::apb_data_t prdata,
	output logic              pready,
	output logic              pslverr,
	output logic              plot_valid,
	output c4_pkg::pix_x_t    plot_x,
	output c4_pkg::pix_y_t    plot_y,
	output c4_pkg::color_t    plot_color
);
	import c4_pkg::*;

	// Move path
	logic   move_req;
	col_t   move_col;
	logic   move_ok;

	// Game state
	board_t board;
	piece_t turn;
	piece_t winner;
	logic   game_over;
	logic   busy;

	// New piece to draw
	logic   placed;
	col_t   placed_col;
	row_t   placed_row;
	piece_t placed_piece;

	c4_apb_regs i_c4_apb_regs (.clk, .reset_n, .psel, .penable, .pwrite, .paddr,
		.pwdata, .prdata, .pready, .pslverr, .move_req, .move_col, .move_ok,
		.board, .turn, .winner, .busy);

	c4_board i_c4_board (.clk, .reset_n, .move_req, .move_col, .move_ok, .busy,
		.game_over, .board, .turn, .placed, .placed_col, .placed_row, .placed_piece);

	c4_win_check i_c4_win_check (.clk, .reset_n, .board, .winner, .game_over);

	c4_cell_plotter i_c4_cell_plotter (.clk, .reset_n, .placed, .placed_col,
		.placed_row, .placed_piece, .busy, .plot_valid, .plot_x, .plot_y, .plot_color);

endmodule

/* dv/connect4_tb.sv */
`timescale 1ns/1ps

module connect4_tb;
	import c4_pkg::*;

	// About 60 moves of about 45 cycles plus a few full board reads
	localparam int MAX_CYCLES = 4000;

	logic      clk;
	logic      reset_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      plot_valid;
	pix_x_t    plot_x;
	pix_y_t    plot_y;
	color_t    plot_color;

	// Reference model of the game
	piece_t ref_cell [NUM_CELLS];
	int     ref_height [NUM_COLS];
	piece_t ref_turn;
	piece_t ref_winner;

	logic   expect_pix;  // Square of the last accepted move
	int     pix_idx;
	int     exp_x0;
	int     exp_y0;
	color_t exp_color;

	int     n_checks;
	int     n_errors;
	int     n_tests;
	int     cycles;
	integer seed;

	connect4_top i_connect4_top (.clk, .reset_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .plot_valid, .plot_x, .plot_y, .plot_color);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic report_error(input string msg);
		n_errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic check_piece(input string name, input piece_t got, input piece_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_coord(input string name, input pix_x_t got, input pix_x_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_color(input string name, input color_t got, input color_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	// Pixel stream runs x fastest across the 6x6 square
	always @(negedge clk) begin
		if (reset_n && plot_valid === 1'b1) begin
			if (!expect_pix || pix_idx >= CELL_PIX * CELL_PIX) begin
				report_error("pixel sent while no piece was waiting to be drawn");
			end else begin
				check_coord("plot_x", plot_x, pix_x_t'(exp_x0 + pix_idx % CELL_PIX));
				check_coord("plot_y", pix_x_t'(plot_y), pix_x_t'(exp_y0 + pix_idx / CELL_PIX));
				check_color("plot_color", plot_color, exp_color);
			end
			pix_idx++;
		end
	end

	//////////////////////////////////////////////////
	// APB access
	//////////////////////////////////////////////////

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);  // Middle of the access phase
		err = pslverr;
		check_bit("pready", pready, 1'b1);
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
		@(posedge clk);
		psel    <= 1'b1;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic piece_t ref_owner(input int r, input int c);
		if (r < 0 || r >= NUM_ROWS || c < 0 || c >= NUM_COLS) begin
			return PIECE_EMPTY;
		end
		return ref_cell[r * NUM_COLS + c];
	endfunction

	// First run of four in row order with four directions per cell
	function automatic piece_t ref_scan();
		int     dr;
		int     dc;
		int     run;
		piece_t p;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int c = 0; c < NUM_COLS; c++) begin
				for (int d = 0; d < 4; d++) begin
					dr = (d == 0) ? 0 : 1;
					dc = (d == 1) ? 0 : ((d == 3) ? -1 : 1);
					p = ref_owner(r, c);
					run = 0;
					for (int k = 0; k < WIN_LEN; k++) begin
						if (p != PIECE_EMPTY && ref_owner(r + k * dr, c + k * dc) == p) run++;
					end
					if (run == WIN_LEN) return p;
				end
			end
		end
		return PIECE_EMPTY;
	endfunction

	task automatic ref_place(input int col);
		int row;
		row = NUM_ROWS - 1 - ref_height[col];  // Lowest empty row
		ref_cell[row * NUM_COLS + col] = ref_turn;
		ref_height[col]++;
		exp_x0 = ORIGIN_X + col * PITCH_X;
		exp_y0 = ORIGIN_Y + row * PITCH_Y;
		exp_color = (ref_turn == PIECE_P1) ? COLOR_P1 : COLOR_P2;
		pix_idx = 0;
		expect_pix = 1'b1;
		ref_turn = (ref_turn == PIECE_P1) ? PIECE_P2 : PIECE_P1;
		if (ref_winner == PIECE_EMPTY) ref_winner = ref_scan();
	endtask

	task automatic reset_dut();
		reset_n <= 1'b0;
		repeat (8) @(posedge clk);
		reset_n <= 1'b1;
		for (int n = 0; n < NUM_CELLS; n++) ref_cell[n] = PIECE_EMPTY;
		for (int c = 0; c < NUM_COLS; c++) ref_height[c] = 0;
		ref_turn = PIECE_P1;
		ref_winner = PIECE_EMPTY;
		expect_pix = 1'b0;
		@(posedge clk);
	endtask

	//////////////////////////////////////////////////
	// Game level tasks
	//////////////////////////////////////////////////

	// Poll until the plotter is done and count the square
	task automatic wait_idle(output apb_data_t st);
		apb_read(REG_STATUS, st);
		while (st[0] !== 1'b0) apb_read(REG_STATUS, st);
		if (expect_pix && pix_idx != CELL_PIX * CELL_PIX) begin
			report_error($sformatf("%0d pixels drawn for a piece instead of 36", pix_idx));
		end
		expect_pix = 1'b0;
	endtask

	task automatic play_move(input int col);
		apb_data_t st;
		logic      err;
		logic      legal;
		wait_idle(st);
		legal = (col < NUM_COLS) && (ref_height[col] < NUM_ROWS) && (ref_winner == PIECE_EMPTY);
		apb_write(REG_MOVE, apb_data_t'(col), err);
		check_bit($sformatf("pslverr move col %0d", col), err, !legal);
		if (legal) ref_place(col);
	endtask

	task automatic check_status(output apb_data_t st);
		wait_idle(st);
		check_piece("turn", st[2:1], ref_turn);
		check_piece("winner", st[4:3], ref_winner);
	endtask

	task automatic check_board();
		apb_data_t d;
		for (int n = 0; n < NUM_CELLS; n++) begin
			apb_read(REG_CELL_BASE + apb_addr_t'(4 * n), d);
			check_piece($sformatf("cell %0d", n), d[1:0], ref_cell[n]);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		n_tests++;
		if (n_errors == errs_before) $display("Test %0d %s: ok", n_tests, name);
		else $display("Test %0d %s: %0d errors", n_tests, name, n_errors - errs_before);
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	initial begin
		apb_data_t st;
		logic      err;
		int        e0;
		int        col;
		int        diag_cols [12];
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		seed = 32'h8e9f1d62;
		diag_cols = '{1, 0, 2, 1, 3, 6, 2, 2, 3, 3, 5, 3};
		reset_dut();

		e0 = n_errors;
		apb_read(REG_STATUS, st);
		check_bit("busy", st[0], 1'b0);
		check_status(st);
		check_board();
		report_test("reset state", e0);

		e0 = n_errors;
		repeat (3) play_move(3);
		check_status(st);
		for (int i = 0; i < 3; i++) begin
			apb_read(REG_CELL_BASE + apb_addr_t'(4 * ((NUM_ROWS - 1 - i) * NUM_COLS + 3)), st);
			check_piece("stacked cell", st[1:0], (i % 2 == 0) ? PIECE_P1 : PIECE_P2);
		end
		check_board();
		report_test("column stacking", e0);

		e0 = n_errors;
		play_move(5);
		apb_write(REG_MOVE, apb_data_t'(2), err);  // Plotter still drawing
		check_bit("pslverr while busy", err, 1'b1);
		check_status(st);
		report_test("pixel sweep", e0);

		e0 = n_errors;
		reset_dut();
		for (int i = 0; i < 7; i++) play_move(i % 2);
		check_status(st);
		check_piece("vertical winner", st[4:3], PIECE_P1);
		play_move(2);
		check_board();
		reset_dut();
		foreach (diag_cols[i]) play_move(diag_cols[i]);
		check_status(st);
		check_piece("diagonal winner", st[4:3], PIECE_P2);
		play_move(4);
		check_board();
		report_test("wins", e0);

		e0 = n_errors;
		reset_dut();
		play_move(7);
		check_status(st);
		check_piece("turn after column 7", st[2:1], PIECE_P1);
		repeat (8) play_move(4);  // Last one hits a full column
		check_status(st);
		check_piece("turn after full column", st[2:1], PIECE_P2);
		report_test("illegal moves", e0);

		e0 = n_errors;
		reset_dut();
		for (int i = 0; i < 16 && ref_winner == PIECE_EMPTY; i++) begin
			col = ($random(seed) & 32'h7fffffff) % NUM_COLS;
			while (ref_height[col] >= NUM_ROWS) col = (col + 1) % NUM_COLS;
			play_move(col);
			check_status(st);
		end
		check_board();
		report_test("random game", e0);

		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* connect4.f */
hw/c4_pkg.sv
hw/c4_apb_regs.sv
hw/c4_board.sv
hw/c4_win_check.sv
hw/c4_cell_plotter.sv
hw/connect4_top.sv
dv/connect4_tb.sv
